// File: axi_burst_pkg.sv
package axi_burst_pkg;

    // burst type field
    localparam logic [1:0] AXI_BURST_FIXED = 2'b00;
    localparam logic [1:0] AXI_BURST_INCR  = 2'b01;

    // beat size field, log2 of bytes per beat
    localparam logic [2:0] AXI_SIZE_WORD = 3'b010;   // 4 bytes per beat

    // id used for every dcache line transfer
    localparam logic [3:0] AXI_ID_DCACHE = 4'b0001;

    // width of arlen / awlen, axi3 style
    localparam int AXI_LEN_W = 4;

    // longest burst that fits the length field
    localparam int AXI_MAX_BEATS = 1 << AXI_LEN_W;

    // okay response, the bridge never looks at it
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

// File: line_bridge_pkg.sv
package line_bridge_pkg;

    // one bus data word and one byte address
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // words per cache line unless the top says otherwise
    localparam int DEFAULT_LINE_WORDS = 4;

    // transfer states, one transfer at a time
    typedef enum logic [2:0] {
        S_IDLE    = 3'd0,
        S_RD_ADDR = 3'd1,   // arvalid up
        S_RD_DATA = 3'd2,   // rready up, collecting beats
        S_WR_ADDR = 3'd3,   // awvalid up
        S_WR_DATA = 3'd4,   // wvalid up, sending beats
        S_WR_RESP = 3'd5    // bready up
    } xfer_state_t;

    // bytes covered by one line of n words
    function automatic int line_bytes(input int n);
        return n * 4;
    endfunction

endpackage

// File: beat_if.sv
`timescale 1ns/1ps

// beat control shared by the fsm, the counter and the two data blocks
interface beat_if #(
    parameter int LINE_WORDS = 4
);
    localparam int IDX_W = $clog2(LINE_WORDS);

    logic             start;      // request accepted this cycle
    logic             is_write;   // direction of the transfer
    logic             step;       // one accepted data beat
    logic [IDX_W-1:0] beat_idx;   // word of the line for this beat
    logic             last_beat;

    modport ctrl (
        output start, is_write, step,
        input  last_beat
    );

    modport count (
        input  start, step,
        output beat_idx, last_beat
    );

    modport data (
        input start, is_write, step, beat_idx, last_beat
    );
endinterface

// File: beat_counter.sv
`timescale 1ns/1ps

module beat_counter #(
    parameter int LINE_WORDS = 4
) (
    input  logic  clk,
    input  logic  reset,
    beat_if.count beat
);
    localparam int IDX_W = $clog2(LINE_WORDS);
    localparam int CNT_W = IDX_W + 1;   // one extra bit to see the end of the burst

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (beat.start) begin
            cnt <= '0;
        end else if (beat.step) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign beat.beat_idx  = cnt[IDX_W-1:0];
    assign beat.last_beat = (cnt == CNT_W'(LINE_WORDS - 1));

    // the fsm must stop stepping once the last beat has gone
    a_no_extra_step: assert property (
        @(posedge clk) disable iff (reset)
        beat.step |-> (cnt <= CNT_W'(LINE_WORDS - 1))
    ) else $error("beat step past end of line, cnt=%0d", cnt);

endmodule

// File: transfer_fsm.sv
`timescale 1ns/1ps

module transfer_fsm (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rd_req,
    input  logic                   wr_req,
    input  line_bridge_pkg::addr_t rd_addr,
    input  line_bridge_pkg::addr_t wr_addr,
    output logic                   rd_rdy,
    output logic                   wr_rdy,
    output line_bridge_pkg::addr_t araddr,
    output line_bridge_pkg::addr_t awaddr,
    output logic                   arvalid,
    output logic                   awvalid,
    output logic                   rready,
    output logic                   wvalid,
    output logic                   bready,
    input  logic                   arready,
    input  logic                   awready,
    input  logic                   rvalid,
    input  logic                   rlast,
    input  logic                   wready,
    input  logic                   bvalid,
    beat_if.ctrl                   beat
);
    import line_bridge_pkg::*;

    xfer_state_t state;
    xfer_state_t state_next;
    addr_t       addr_q;      // held while arvalid / awvalid is up
    logic        wr_q;        // direction of the running transfer
    logic        accept;

    // write wins a tie so the victim line leaves before the refill
    assign accept = (state == S_IDLE) && (rd_req || wr_req);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            wr_q  <= 1'b0;
        end else begin
            state <= state_next;
            if (accept)
                wr_q <= wr_req;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            addr_q <= wr_req ? wr_addr : rd_addr;
    end

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (wr_req)
                    state_next = S_WR_ADDR;
                else if (rd_req)
                    state_next = S_RD_ADDR;
            end
            S_RD_ADDR: if (arready) state_next = S_RD_DATA;
            S_RD_DATA: if (rvalid && beat.last_beat) state_next = S_IDLE;
            S_WR_ADDR: if (awready) state_next = S_WR_DATA;
            S_WR_DATA: if (wready && beat.last_beat) state_next = S_WR_RESP;
            S_WR_RESP: if (bvalid) state_next = S_IDLE;
            default:   state_next = S_IDLE;
        endcase
    end

    // beat control toward the counter and data blocks
    assign beat.start    = accept;
    assign beat.is_write = (state == S_IDLE) ? wr_req : wr_q;
    assign beat.step     = (state == S_RD_DATA && rvalid) ||
                           (state == S_WR_DATA && wready);

    assign araddr  = addr_q;
    assign awaddr  = addr_q;
    assign arvalid = (state == S_RD_ADDR);
    assign rready  = (state == S_RD_DATA);
    assign awvalid = (state == S_WR_ADDR);
    assign wvalid  = (state == S_WR_DATA);
    assign bready  = (state == S_WR_RESP);

    // a read loses to a write in the same idle cycle
    assign wr_rdy = (state == S_IDLE);
    assign rd_rdy = (state == S_IDLE) && !wr_req;

    // slave burst length and our beat count must agree
    a_rlast_match: assert property (
        @(posedge clk) disable iff (reset)
        (rvalid && rready) |-> (rlast == beat.last_beat)
    ) else $error("rlast=%0b but last_beat=%0b", rlast, beat.last_beat);

    // the slave answers only after the last w beat
    a_b_in_resp: assert property (
        @(posedge clk) disable iff (reset)
        bvalid |-> (state == S_WR_RESP)
    ) else $error("bvalid outside the write response phase");

endmodule

// File: line_assembler.sv
`timescale 1ns/1ps

module line_assembler #(
    parameter int LINE_WORDS = 4
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  line_bridge_pkg::word_t                  rdata,
    output logic                                    ret_valid,
    output line_bridge_pkg::word_t [LINE_WORDS-1:0] ret_data,
    beat_if.data                                    beat
);
    import line_bridge_pkg::*;

    localparam int IDX_W = $clog2(LINE_WORDS);

    word_t [LINE_WORDS-1:0] line_q;   // word 0 in the low bits
    logic                   rd_step;
    logic [IDX_W-1:0]       wr_ptr;

    assign rd_step = beat.step && !beat.is_write;
    assign wr_ptr  = beat.beat_idx;

    // beats land in the line as they are accepted
    always_ff @(posedge clk) begin
        if (rd_step)
            line_q[wr_ptr] <= rdata;
    end

    // one pulse, the cycle after the final r beat
    always_ff @(posedge clk) begin
        if (reset)
            ret_valid <= 1'b0;
        else
            ret_valid <= rd_step && beat.last_beat;
    end

    assign ret_data = line_q;

endmodule

// File: line_serializer.sv
`timescale 1ns/1ps

module line_serializer #(
    parameter int LINE_WORDS = 4
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  line_bridge_pkg::word_t [LINE_WORDS-1:0] wr_data,
    output line_bridge_pkg::word_t                  wdata,
    output logic                                    wlast,
    beat_if.data                                    beat
);
    import line_bridge_pkg::*;

    word_t [LINE_WORDS-1:0] line_q;
    logic                   load;
    logic                   wr_busy;   // line latched, w beats still owed

    assign load = beat.start && beat.is_write;

    // cache only holds wr_data until the accept edge
    always_ff @(posedge clk) begin
        if (load)
            line_q <= wr_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_busy <= 1'b0;
        end else if (load) begin
            wr_busy <= 1'b1;
        end else if (beat.step && beat.last_beat) begin
            wr_busy <= 1'b0;   // final w beat accepted
        end
    end

    // word follows the beat index without a register stage
    assign wdata = line_q[beat.beat_idx];
    assign wlast = wr_busy && beat.last_beat;

    // no new write may be accepted before the current line has gone out
    a_no_reload: assert property (
        @(posedge clk) disable iff (reset)
        load |-> !wr_busy
    ) else $error("write line reloaded during a burst");

endmodule

// File: line_bridge_top.sv
`timescale 1ns/1ps

module line_bridge_top #(
    parameter int LINE_WORDS = line_bridge_pkg::DEFAULT_LINE_WORDS
) (
    input  logic                                        clk,
    input  logic                                        reset,
    // dcache side
    input  logic                                        rd_req,
    input  line_bridge_pkg::addr_t                      rd_addr,
    output logic                                        rd_rdy,
    output logic                                        ret_valid,
    output line_bridge_pkg::word_t [LINE_WORDS-1:0]     ret_data,
    input  logic                                        wr_req,
    input  line_bridge_pkg::addr_t                      wr_addr,
    input  line_bridge_pkg::word_t [LINE_WORDS-1:0]     wr_data,
    output logic                                        wr_rdy,
    // ar channel
    output logic [3:0]                                  arid,
    output line_bridge_pkg::addr_t                      araddr,
    output logic [axi_burst_pkg::AXI_LEN_W-1:0]         arlen,
    output logic [2:0]                                  arsize,
    output logic [1:0]                                  arburst,
    output logic                                        arvalid,
    input  logic                                        arready,
    // r channel
    input  line_bridge_pkg::word_t                      rdata,
    input  logic                                        rlast,
    input  logic                                        rvalid,
    output logic                                        rready,
    // aw channel
    output logic [3:0]                                  awid,
    output line_bridge_pkg::addr_t                      awaddr,
    output logic [axi_burst_pkg::AXI_LEN_W-1:0]         awlen,
    output logic [2:0]                                  awsize,
    output logic [1:0]                                  awburst,
    output logic                                        awvalid,
    input  logic                                        awready,
    // w channel
    output line_bridge_pkg::word_t                      wdata,
    output logic                                        wlast,
    output logic                                        wvalid,
    input  logic                                        wready,
    // b channel
    input  logic                                        bvalid,
    output logic                                        bready
);
    import axi_burst_pkg::*;

    beat_if #(.LINE_WORDS(LINE_WORDS)) beat_bus ();

    // every transfer is one full line, incrementing
    assign arid    = AXI_ID_DCACHE;
    assign arlen   = AXI_LEN_W'(LINE_WORDS - 1);
    assign arsize  = AXI_SIZE_WORD;
    assign arburst = AXI_BURST_INCR;
    assign awid    = AXI_ID_DCACHE;
    assign awlen   = AXI_LEN_W'(LINE_WORDS - 1);
    assign awsize  = AXI_SIZE_WORD;
    assign awburst = AXI_BURST_INCR;

    transfer_fsm u_fsm (
        .clk     (clk),
        .reset   (reset),
        .rd_req  (rd_req),
        .wr_req  (wr_req),
        .rd_addr (rd_addr),
        .wr_addr (wr_addr),
        .rd_rdy  (rd_rdy),
        .wr_rdy  (wr_rdy),
        .araddr  (araddr),
        .awaddr  (awaddr),
        .arvalid (arvalid),
        .awvalid (awvalid),
        .rready  (rready),
        .wvalid  (wvalid),
        .bready  (bready),
        .arready (arready),
        .awready (awready),
        .rvalid  (rvalid),
        .rlast   (rlast),
        .wready  (wready),
        .bvalid  (bvalid),
        .beat    (beat_bus.ctrl)
    );

    beat_counter #(.LINE_WORDS(LINE_WORDS)) u_counter (
        .clk   (clk),
        .reset (reset),
        .beat  (beat_bus.count)
    );

    line_assembler #(.LINE_WORDS(LINE_WORDS)) u_assembler (
        .clk       (clk),
        .reset     (reset),
        .rdata     (rdata),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .beat      (beat_bus.data)
    );

    line_serializer #(.LINE_WORDS(LINE_WORDS)) u_serializer (
        .clk     (clk),
        .reset   (reset),
        .wr_data (wr_data),
        .wdata   (wdata),
        .wlast   (wlast),
        .beat    (beat_bus.data)
    );

endmodule

// File: axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model #(
    parameter int MEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] araddr,
    input  logic [3:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready,
    input  logic [31:0] awaddr,
    input  logic [3:0]  awlen,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready
);
    typedef enum logic [1:0] {M_IDLE, M_RD, M_WR, M_B} mem_state_t;

    logic [31:0] mem [MEM_WORDS];
    mem_state_t  mst;
    logic [7:0]  base;     // word address of the burst
    logic [3:0]  len_q;
    logic [3:0]  idx;
    logic [3:0]  nxt;

    // pattern depends on every address bit
    initial begin
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = (32'(i) * 32'h9e37_79b9) ^ {24'h5a5a5a, 8'(i)};
    end

    always @(posedge clk) begin
        if (reset) begin
            mst     <= M_IDLE;
            arready <= 1'b0;
            awready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            case (mst)
                M_IDLE: begin
                    if (arvalid && arready) begin
                        base    <= araddr[9:2];
                        len_q   <= arlen;
                        idx     <= '0;
                        arready <= 1'b0;
                        awready <= 1'b0;
                        mst     <= M_RD;
                    end else if (awvalid && awready) begin
                        base    <= awaddr[9:2];
                        len_q   <= awlen;
                        idx     <= '0;
                        arready <= 1'b0;
                        awready <= 1'b0;
                        wready  <= ($urandom % 3) != 0;
                        mst     <= M_WR;
                    end else begin
                        arready <= ($urandom % 4) != 0;   // random address stalls
                        awready <= ($urandom % 4) != 0;
                    end
                end
                M_RD: begin
                    if (rvalid && !rready) begin
                        // hold the beat until taken
                    end else if (rvalid && rlast) begin
                        rvalid <= 1'b0;
                        rlast  <= 1'b0;
                        mst    <= M_IDLE;
                    end else begin
                        nxt = rvalid ? idx + 4'd1 : idx;
                        idx <= nxt;
                        if (($urandom % 3) != 0) begin
                            rvalid <= 1'b1;
                            rdata  <= mem[base + 8'(nxt)];
                            rlast  <= (nxt == len_q);
                        end else begin
                            rvalid <= 1'b0;
                        end
                    end
                end
                M_WR: begin
                    if (wvalid && wready) begin
                        mem[base + 8'(idx)] <= wdata;
                        idx <= idx + 4'd1;
                        if (idx == len_q) begin
                            wready <= 1'b0;
                            mst    <= M_B;
                        end else begin
                            wready <= ($urandom % 3) != 0;
                        end
                    end else begin
                        wready <= ($urandom % 3) != 0;
                    end
                end
                default: begin
                    if (bvalid && bready) begin
                        bvalid <= 1'b0;
                        mst    <= M_IDLE;
                    end else if (!bvalid) begin
                        bvalid <= ($urandom % 2) != 0;
                    end
                end
            endcase
        end
    end

endmodule

// File: tb_line_bridge.sv
`timescale 1ns/1ps

module tb_line_bridge;
    import line_bridge_pkg::*;
    import axi_burst_pkg::*;

    localparam int LW         = DEFAULT_LINE_WORDS;
    localparam int NUM_OPS    = 200;
    localparam int MAX_CYCLES = NUM_OPS * 64;
    localparam int NUM_LINES  = 256 / LW;

    logic clk, reset;
    logic rd_req, wr_req, rd_rdy, wr_rdy, ret_valid;
    addr_t rd_addr, wr_addr, araddr, awaddr;
    word_t [LW-1:0] ret_data, wr_data;
    logic [3:0] arid, awid, arlen, awlen;
    logic [2:0] arsize, awsize;
    logic [1:0] arburst, awburst;
    logic arvalid, arready, rlast, rvalid, rready;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    word_t rdata, wdata;

    word_t shadow [256];   // reference copy of slave memory
    int    errors;
    int    cycles;
    int    w_beats;
    logic  rlast_seen;     // last r beat taken on the previous edge
    logic  expect_aw_first;
    addr_t exp_ar_addr, exp_aw_addr;

    always #20 clk = ~clk;

    line_bridge_top #(.LINE_WORDS(LW)) dut0 (.*);

    axi_mem_model mem0 (.*);

    task automatic check_eq(input logic [255:0] got, input logic [255:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    function automatic word_t fill_word(input int i);
        return (32'(i) * 32'h9e37_79b9) ^ {24'h5a5a5a, 8'(i)};
    endfunction

    function automatic logic [LW*32-1:0] shadow_line(input addr_t a);
        logic [LW*32-1:0] l;
        for (int w = 0; w < LW; w++)
            l[w*32 +: 32] = shadow[a[9:2] + 8'(w)];   // word 0 lowest
        return l;
    endfunction

    task automatic store_line(input addr_t a, input logic [LW*32-1:0] l);
        for (int w = 0; w < LW; w++)
            shadow[a[9:2] + 8'(w)] = l[w*32 +: 32];
    endtask

    task automatic wait_ret_and_check(input addr_t a);
        while (!ret_valid) begin
            @(posedge clk);
            #2;
        end
        check_eq(256'(ret_data), 256'(shadow_line(a)), "read line data");
    endtask

    task automatic wait_write_done();
        while (!wr_rdy) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic do_read(input addr_t a);
        rd_req = 1'b1;
        rd_addr = a;
        exp_ar_addr = a;
        @(posedge clk);
        #2;
        rd_req = 1'b0;
        wait_ret_and_check(a);
    endtask

    task automatic do_write(input addr_t a, input logic [LW*32-1:0] l);
        wr_req = 1'b1;
        wr_addr = a;
        wr_data = l;
        exp_aw_addr = a;
        @(posedge clk);
        #2;
        wr_req = 1'b0;
        store_line(a, l);
        wait_write_done();
    endtask

    // read and write raised together, same line
    task automatic do_tie(input addr_t a, input logic [LW*32-1:0] l);
        rd_req = 1'b1;
        wr_req = 1'b1;
        rd_addr = a;
        wr_addr = a;
        wr_data = l;
        exp_ar_addr = a;
        exp_aw_addr = a;
        expect_aw_first = 1'b1;
        @(posedge clk);
        #2;
        wr_req = 1'b0;
        store_line(a, l);
        wait_write_done();
        @(posedge clk);   // held read is taken here
        #2;
        rd_req = 1'b0;
        wait_ret_and_check(a);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run timed out after %0d cycles, bridge state %s",
                     cycles, dut0.u_fsm.state.name());
            $display("Test failed");
            $finish;
        end
    end

    // bus monitor, samples pre-edge values
    always @(posedge clk) begin
        if (!reset) begin
            check_eq(256'(ret_valid), 256'(rlast_seen), "ret_valid after last r beat");
            rlast_seen = rvalid && rready && rlast;
            if (arvalid && arready) begin
                check_eq(256'(arid), 256'(AXI_ID_DCACHE), "arid");
                check_eq(256'(arlen), 256'(LW - 1), "arlen");
                check_eq(256'(arsize), 256'(AXI_SIZE_WORD), "arsize");
                check_eq(256'(arburst), 256'(AXI_BURST_INCR), "arburst");
                check_eq(256'(araddr), 256'(exp_ar_addr), "araddr");
                check_eq(256'(expect_aw_first), 256'(0), "aw before ar on tie");
            end
            if (awvalid && awready) begin
                check_eq(256'(awid), 256'(AXI_ID_DCACHE), "awid");
                check_eq(256'(awlen), 256'(LW - 1), "awlen");
                check_eq(256'(awsize), 256'(AXI_SIZE_WORD), "awsize");
                check_eq(256'(awburst), 256'(AXI_BURST_INCR), "awburst");
                check_eq(256'(awaddr), 256'(exp_aw_addr), "awaddr");
                expect_aw_first = 1'b0;
                w_beats = 0;
            end
            if (wvalid && wready) begin
                check_eq(256'(wlast), 256'(w_beats == LW - 1), "wlast position");
                w_beats++;
            end
            if (bready)
                check_eq(256'(w_beats), 256'(LW), "w beats per burst");
        end
    end

    initial begin
        addr_t            a;
        logic [LW*32-1:0] l;
        int               op;

        void'($urandom(32'hd437));
        clk = 1'b0;
        reset = 1'b1;
        rd_req = 1'b0;
        wr_req = 1'b0;
        rd_addr = '0;
        wr_addr = '0;
        wr_data = '0;
        errors = 0;
        cycles = 0;
        w_beats = 0;
        rlast_seen = 1'b0;
        expect_aw_first = 1'b0;
        exp_ar_addr = '0;
        exp_aw_addr = '0;
        for (int i = 0; i < 256; i++)
            shadow[i] = fill_word(i);

        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        check_eq(256'({arvalid, awvalid, wvalid, rready, bready, ret_valid}), 256'(0),
                 "outputs low after reset");
        check_eq(256'({rd_rdy, wr_rdy}), 256'(2'b11), "ready high after reset");

        for (int n = 0; n < NUM_OPS; n++) begin
            op = $urandom % 3;
            a = addr_t'(($urandom % NUM_LINES) * LW * 4);
            for (int w = 0; w < LW; w++)
                l[w*32 +: 32] = $urandom;
            if (op == 0)
                do_read(a);
            else if (op == 1)
                do_write(a, l);
            else
                do_tie(a, l);
        end

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: vlog.f
axi_burst_pkg.sv
line_bridge_pkg.sv
beat_if.sv
beat_counter.sv
transfer_fsm.sv
line_assembler.sv
line_serializer.sv
line_bridge_top.sv
axi_mem_model.sv
tb_line_bridge.sv

// File: run_sim.sh
#!/bin/sh
# build and run the line bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_line_bridge -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_line_bridge > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error"
fi

cat sim.log
if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
exit 1
